// File: source/dcache_pkg.sv
package dcache_pkg;

  // address geometry
  localparam int PADDR_W    = 32;
  localparam int LINE_BYTES = 16;
  localparam int OFFSET_W   = 4;
  localparam int SETS       = 16;
  localparam int INDEX_W    = 4;
  localparam int TAG_W      = PADDR_W - INDEX_W - OFFSET_W;

  // organisation
  localparam int WAYS     = 4;
  localparam int WAY_W    = 2;
  localparam int LINE_W   = LINE_BYTES * 8;
  localparam int RD_PORTS = 3;

  // field positions inside paddr
  localparam int INDEX_LSB = OFFSET_W;
  localparam int TAG_LSB   = OFFSET_W + INDEX_W;

  // one read request per port
  typedef struct packed {
    logic               valid;
    logic               h_pri;
    logic [PADDR_W-1:0] paddr;
  } dc_rd_req_t;

  // read response, all flags are single-cycle pulses
  typedef struct packed {
    logic               hit;
    logic               miss;
    logic               conflict;
    logic [WAY_W-1:0]   hit_way;
    logic [LINE_W-1:0]  data;
    // victim candidate for the refill logic
    logic               replace_valid;
    logic [WAY_W-1:0]   replace_way;
    logic [LINE_W-1:0]  replace_data;
    logic [PADDR_W-1:0] replace_paddr;
  } dc_rd_resp_t;

  // single write port
  typedef struct packed {
    logic                  valid;
    // 1 = fill, 0 = store
    logic                  tag_update;
    logic [WAY_W-1:0]      way;
    logic [PADDR_W-1:0]    paddr;
    logic [LINE_BYTES-1:0] be;
    logic [LINE_W-1:0]     data;
  } dc_wr_req_t;

  typedef struct packed {
    logic hit;
    logic miss;
  } dc_wr_resp_t;

endpackage

// File: source/dcache_read_arb.sv
`timescale 1ns/1ps

module dcache_read_arb
  import dcache_pkg::*;
(
  input  dc_rd_req_t          i_dc_rd_req [RD_PORTS],
  output logic [RD_PORTS-1:0] o_sel_oh,
  output logic [PADDR_W-1:0]  o_sel_paddr,
  output logic [RD_PORTS-1:0] o_same_line,
  output logic                o_any_valid
);

  logic [RD_PORTS-1:0] w_valid;
  logic [RD_PORTS-1:0] w_h_pri;
  logic [RD_PORTS-1:0] w_h_pri_oh;
  logic [RD_PORTS-1:0] w_norm_oh;

  always_comb begin
    for (int p = 0; p < RD_PORTS; p++) begin
      w_valid[p] = i_dc_rd_req[p].valid;
      w_h_pri[p] = i_dc_rd_req[p].valid & i_dc_rd_req[p].h_pri;
    end
  end

  // isolate lowest set bit
  assign w_h_pri_oh = w_h_pri & (~w_h_pri + RD_PORTS'(1));
  assign w_norm_oh  = w_valid & (~w_valid + RD_PORTS'(1));

  assign o_sel_oh    = (|w_h_pri_oh) ? w_h_pri_oh : w_norm_oh;
  assign o_any_valid = |w_valid;

  always_comb begin
    o_sel_paddr = '0;
    for (int p = 0; p < RD_PORTS; p++) begin
      if (o_sel_oh[p]) begin
        o_sel_paddr = o_sel_paddr | i_dc_rd_req[p].paddr;
      end
    end
  end

  // ports riding along on the chosen line
  always_comb begin
    for (int p = 0; p < RD_PORTS; p++) begin
      o_same_line[p] = w_valid[p] &
                       (i_dc_rd_req[p].paddr[PADDR_W-1:OFFSET_W] ==
                        o_sel_paddr[PADDR_W-1:OFFSET_W]);
    end
  end

endmodule

// File: source/dcache_tag_array.sv
`timescale 1ns/1ps

module dcache_tag_array
  import dcache_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_wr,
  input  logic [INDEX_W-1:0] i_addr,
  input  logic [TAG_W-1:0]   i_tag,
  output logic [TAG_W-1:0]   o_tag,
  output logic               o_tag_valid
);

  logic [SETS-1:0]  r_valid;
  logic [TAG_W-1:0] r_tag [SETS];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid     <= '0;
      o_tag_valid <= 1'b0;
    end else begin
      // old contents come out on a same-cycle write
      o_tag_valid <= r_valid[i_addr];
      if (i_wr) begin
        r_valid[i_addr] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    o_tag <= r_tag[i_addr];
    if (i_wr) begin
      r_tag[i_addr] <= i_tag;
    end
  end

endmodule

// File: source/dcache_data_array.sv
`timescale 1ns/1ps

module dcache_data_array
  import dcache_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_wr,
  input  logic [INDEX_W-1:0]    i_addr,
  input  logic [LINE_BYTES-1:0] i_be,
  input  logic [LINE_W-1:0]     i_data,
  output logic [LINE_W-1:0]     o_data
);

  logic [LINE_W-1:0] r_mem [SETS];

  // registered read port
  always_ff @(posedge i_clk) begin
    o_data <= r_mem[i_addr];
  end

  // byte-enable write
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (i_be[b]) begin
          r_mem[i_addr][b*8 +: 8] <= i_data[b*8 +: 8];
        end
      end
    end
  end

endmodule

// File: source/dcache_hit_resp.sv
`timescale 1ns/1ps

module dcache_hit_resp
  import dcache_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,

  // way outputs of the arrays
  input  logic [TAG_W-1:0]    i_tag [WAYS],
  input  logic [WAYS-1:0]     i_tag_valid,
  input  logic [LINE_W-1:0]   i_data [WAYS],

  // stage-1 read state
  input  logic [RD_PORTS-1:0] i_rd_valid,
  input  logic [RD_PORTS-1:0] i_sel_oh,
  input  logic [RD_PORTS-1:0] i_same_line,
  input  logic [TAG_W-1:0]    i_rd_tag [RD_PORTS],
  input  logic [INDEX_W-1:0]  i_index,

  // stage-1 write state
  input  logic                i_wr_valid,
  input  logic                i_wr_fill,
  input  logic                i_data_busy,
  input  logic [TAG_W-1:0]    i_wr_tag,

  output dc_rd_resp_t         o_dc_rd_resp [RD_PORTS],
  output dc_wr_resp_t         o_dc_wr_resp,
  output logic [WAY_W-1:0]    o_store_hit_way,
  output logic                o_store_hit
);

  logic [WAY_W-1:0]    r_victim [SETS];
  logic [WAY_W-1:0]    w_victim_way;
  logic [PADDR_W-1:0]  w_victim_paddr;
  logic [RD_PORTS-1:0] w_rd_miss;
  logic [WAYS-1:0]     w_wr_hit;
  logic                w_wr_any_hit;

  // victim is the set's counter before this access
  assign w_victim_way   = r_victim[i_index];
  assign w_victim_paddr = {i_tag[w_victim_way], i_index, {OFFSET_W{1'b0}}};

  for (genvar p = 0; p < RD_PORTS; p++) begin : g_port
    logic [WAYS-1:0]  w_hit;
    logic [WAY_W-1:0] w_hit_way;
    logic             w_served;

    always_comb begin
      for (int w = 0; w < WAYS; w++) begin
        w_hit[w] = i_tag_valid[w] & (i_tag[w] == i_rd_tag[p]);
      end
    end

    always_comb begin
      w_hit_way = '0;
      for (int w = 0; w < WAYS; w++) begin
        if (w_hit[w]) begin
          w_hit_way = WAY_W'(w);
        end
      end
    end

    // no write in the way, and either chosen or on the chosen line
    assign w_served = i_rd_valid[p] & ~i_wr_valid & ~i_data_busy &
                      (i_sel_oh[p] | i_same_line[p]);

    assign o_dc_rd_resp[p].hit           = w_served & (|w_hit);
    assign o_dc_rd_resp[p].miss          = w_served & ~(|w_hit);
    assign o_dc_rd_resp[p].conflict      = i_rd_valid[p] & ~w_served;
    assign o_dc_rd_resp[p].hit_way       = w_hit_way;
    assign o_dc_rd_resp[p].data          = i_data[w_hit_way];
    assign o_dc_rd_resp[p].replace_valid = i_tag_valid[w_victim_way];
    assign o_dc_rd_resp[p].replace_way   = w_victim_way;
    assign o_dc_rd_resp[p].replace_data  = i_data[w_victim_way];
    assign o_dc_rd_resp[p].replace_paddr = w_victim_paddr;

    assign w_rd_miss[p] = o_dc_rd_resp[p].miss;
  end

  // write lookup against the old tags
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      w_wr_hit[w] = i_tag_valid[w] & (i_tag[w] == i_wr_tag);
    end
  end

  assign w_wr_any_hit = |w_wr_hit;

  always_comb begin
    o_store_hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (w_wr_hit[w]) begin
        o_store_hit_way = WAY_W'(w);
      end
    end
  end

  assign o_store_hit       = i_wr_valid & ~i_wr_fill & w_wr_any_hit;
  assign o_dc_wr_resp.hit  = i_wr_valid & w_wr_any_hit;
  assign o_dc_wr_resp.miss = i_wr_valid & ~w_wr_any_hit;

  // round-robin victim per set, all served ports share one set
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int s = 0; s < SETS; s++) begin
        r_victim[s] <= '0;
      end
    end else if (|w_rd_miss) begin
      r_victim[i_index] <= w_victim_way + WAY_W'(1);
    end
  end

endmodule

// File: source/dcache_array.sv
`timescale 1ns/1ps

module dcache_array
  import dcache_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_reset_n,
  input  dc_wr_req_t  i_dc_wr_req,
  output dc_wr_resp_t o_dc_wr_resp,
  input  dc_rd_req_t  i_dc_rd_req  [RD_PORTS],
  output dc_rd_resp_t o_dc_rd_resp [RD_PORTS]
);

  // stage 0
  logic [RD_PORTS-1:0]   w_s0_sel_oh;
  logic [PADDR_W-1:0]    w_s0_sel_paddr;
  logic [RD_PORTS-1:0]   w_s0_same_line;
  logic                  w_s0_any_valid;
  logic [PADDR_W-1:0]    w_s0_paddr;
  logic [INDEX_W-1:0]    w_s0_index;
  logic                  w_s0_tag_wr;

  // stage 1
  logic [RD_PORTS-1:0]   r_s1_rd_valid;
  logic [RD_PORTS-1:0]   r_s1_sel_oh;
  logic [RD_PORTS-1:0]   r_s1_same_line;
  logic [TAG_W-1:0]      r_s1_rd_tag [RD_PORTS];
  logic [INDEX_W-1:0]    r_s1_index;
  logic                  r_s1_wr_valid;
  logic                  r_s1_wr_fill;
  logic                  r_s1_data_busy;
  logic [WAY_W-1:0]      r_s1_wr_way;
  logic [TAG_W-1:0]      r_s1_wr_tag;
  logic [LINE_BYTES-1:0] r_s1_wr_be;
  logic [LINE_W-1:0]     r_s1_wr_data;

  logic [TAG_W-1:0]      w_s1_tag [WAYS];
  logic [WAYS-1:0]       w_s1_tag_valid;
  logic [LINE_W-1:0]     w_s1_data [WAYS];
  logic                  w_s1_store_hit;
  logic [WAY_W-1:0]      w_s1_store_hit_way;
  logic                  w_s1_fill;
  logic [INDEX_W-1:0]    w_data_addr;

  dcache_read_arb u_read_arb (
    .i_dc_rd_req (i_dc_rd_req),
    .o_sel_oh    (w_s0_sel_oh),
    .o_sel_paddr (w_s0_sel_paddr),
    .o_same_line (w_s0_same_line),
    .o_any_valid (w_s0_any_valid)
  );

  // write wins the access address
  assign w_s0_paddr  = i_dc_wr_req.valid ? i_dc_wr_req.paddr : w_s0_sel_paddr;
  assign w_s0_index  = w_s0_paddr[INDEX_LSB +: INDEX_W];
  assign w_s0_tag_wr = i_dc_wr_req.valid & i_dc_wr_req.tag_update;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_rd_valid  <= '0;
      r_s1_sel_oh    <= '0;
      r_s1_same_line <= '0;
      r_s1_wr_valid  <= 1'b0;
      r_s1_wr_fill   <= 1'b0;
      r_s1_data_busy <= 1'b0;
    end else begin
      for (int p = 0; p < RD_PORTS; p++) begin
        r_s1_rd_valid[p] <= i_dc_rd_req[p].valid;
      end
      r_s1_sel_oh    <= w_s0_sel_oh;
      r_s1_same_line <= w_s0_same_line;
      r_s1_wr_valid  <= i_dc_wr_req.valid;
      r_s1_wr_fill   <= w_s0_tag_wr;
      // data arrays belong to the write in its stage 1
      r_s1_data_busy <= r_s1_wr_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    for (int p = 0; p < RD_PORTS; p++) begin
      r_s1_rd_tag[p] <= i_dc_rd_req[p].paddr[TAG_LSB +: TAG_W];
    end
    // hold the set index while idle
    if (i_dc_wr_req.valid | w_s0_any_valid) begin
      r_s1_index <= w_s0_index;
    end
    r_s1_wr_way  <= i_dc_wr_req.way;
    r_s1_wr_tag  <= i_dc_wr_req.paddr[TAG_LSB +: TAG_W];
    r_s1_wr_be   <= i_dc_wr_req.be;
    r_s1_wr_data <= i_dc_wr_req.data;
  end

  assign w_s1_fill   = r_s1_wr_valid & r_s1_wr_fill;
  assign w_data_addr = (w_s1_fill | w_s1_store_hit) ? r_s1_index : w_s0_index;

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    dcache_tag_array u_tag (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_wr        (w_s0_tag_wr & (i_dc_wr_req.way == WAY_W'(w))),
      .i_addr      (w_s0_index),
      .i_tag       (i_dc_wr_req.paddr[TAG_LSB +: TAG_W]),
      .o_tag       (w_s1_tag[w]),
      .o_tag_valid (w_s1_tag_valid[w])
    );

    dcache_data_array u_data (
      .i_clk  (i_clk),
      .i_wr   ((w_s1_fill & (r_s1_wr_way == WAY_W'(w))) |
               (w_s1_store_hit & (w_s1_store_hit_way == WAY_W'(w)))),
      .i_addr (w_data_addr),
      .i_be   (r_s1_wr_be),
      .i_data (r_s1_wr_data),
      .o_data (w_s1_data[w])
    );
  end

  dcache_hit_resp u_hit_resp (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_tag           (w_s1_tag),
    .i_tag_valid     (w_s1_tag_valid),
    .i_data          (w_s1_data),
    .i_rd_valid      (r_s1_rd_valid),
    .i_sel_oh        (r_s1_sel_oh),
    .i_same_line     (r_s1_same_line),
    .i_rd_tag        (r_s1_rd_tag),
    .i_index         (r_s1_index),
    .i_wr_valid      (r_s1_wr_valid),
    .i_wr_fill       (r_s1_wr_fill),
    .i_data_busy     (r_s1_data_busy),
    .i_wr_tag        (r_s1_wr_tag),
    .o_dc_rd_resp    (o_dc_rd_resp),
    .o_dc_wr_resp    (o_dc_wr_resp),
    .o_store_hit_way (w_s1_store_hit_way),
    .o_store_hit     (w_s1_store_hit)
  );

endmodule

// File: test/tb_dcache_array.sv
`timescale 1ns/1ps

module tb_dcache_array
  import dcache_pkg::*;
();

  localparam int NUM_FIELDS = 35;
  localparam int MAX_CYCLES = 200;
  localparam int RESET_WAIT = 20;

  logic        clk;
  logic        reset_n;
  dc_wr_req_t  wr_req;
  dc_wr_resp_t wr_resp;
  dc_rd_req_t  rd_req  [RD_PORTS];
  dc_rd_resp_t rd_resp [RD_PORTS];

  // one parsed stimulus line
  logic [3:0]          f_wv;
  logic [3:0]          f_wf;
  logic [3:0]          f_wway;
  logic [3:0]          f_ewr;
  logic [31:0]         f_wpaddr;
  logic [15:0]         f_wbe;
  logic [LINE_W-1:0]   f_wdata;
  logic [3:0]          f_rv [RD_PORTS];
  logic [3:0]          f_rh [RD_PORTS];
  logic [31:0]         f_ra [RD_PORTS];
  logic [3:0]          f_fl [RD_PORTS];
  logic [3:0]          f_way [RD_PORTS];
  logic [3:0]          f_rvld [RD_PORTS];
  logic [3:0]          f_rway [RD_PORTS];
  logic [LINE_W-1:0]   f_edata [RD_PORTS];
  logic [31:0]         f_erpa [RD_PORTS];
  logic [11:0]         f_mask;

  // expected responses, one line behind the stimulus
  dc_wr_resp_t         prev_wr;
  dc_rd_resp_t         prev_rd [RD_PORTS];
  logic [11:0]         prev_mask;
  logic                have_prev;

  dcache_array u_dcache_array (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_dc_wr_req  (wr_req),
    .o_dc_wr_resp (wr_resp),
    .i_dc_rd_req  (rd_req),
    .o_dc_rd_resp (rd_resp)
  );

  always #10 clk = ~clk;

  initial begin
    clk     = 1'b0;
    reset_n = 1'b0;
    wr_req  = '0;
    for (int p = 0; p < RD_PORTS; p++) begin
      rd_req[p] = '0;
    end
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(input string what, input logic [LINE_W-1:0] got_val,
                                 input logic [LINE_W-1:0] exp_val);
    abort_run($sformatf("MISMATCH at %0t: %s got %h expected %h",
                        $time, what, got_val, exp_val));
  endtask

  task automatic check_wr_resp(input dc_wr_resp_t got, input dc_wr_resp_t exp);
    if (got !== exp) begin
      report_mismatch("write response hit/miss", LINE_W'(got), LINE_W'(exp));
    end
  endtask

  // mask bit0 hit way and data, bit1 victim way, bit2 victim data and address
  task automatic check_rd_resp(input int port, input dc_rd_resp_t got,
                               input dc_rd_resp_t exp, input logic [3:0] mask);
    if ({got.hit, got.miss, got.conflict} !== {exp.hit, exp.miss, exp.conflict}) begin
      report_mismatch($sformatf("rd port %0d hit/miss/conflict", port),
                      LINE_W'({got.hit, got.miss, got.conflict}),
                      LINE_W'({exp.hit, exp.miss, exp.conflict}));
    end
    if (mask[0] && got.hit_way !== exp.hit_way) begin
      report_mismatch($sformatf("rd port %0d hit_way", port), got.hit_way, exp.hit_way);
    end
    if (mask[0] && got.data !== exp.data) begin
      report_mismatch($sformatf("rd port %0d data", port), got.data, exp.data);
    end
    if (mask[1] && {got.replace_valid, got.replace_way} !==
                   {exp.replace_valid, exp.replace_way}) begin
      report_mismatch($sformatf("rd port %0d replace_valid/way", port),
                      {got.replace_valid, got.replace_way},
                      {exp.replace_valid, exp.replace_way});
    end
    if (mask[2] && got.replace_data !== exp.replace_data) begin
      report_mismatch($sformatf("rd port %0d replace_data", port),
                      got.replace_data, exp.replace_data);
    end
    if (mask[2] && got.replace_paddr !== exp.replace_paddr) begin
      report_mismatch($sformatf("rd port %0d replace_paddr", port),
                      got.replace_paddr, exp.replace_paddr);
    end
  endtask

  task automatic verify_responses();
    check_wr_resp(wr_resp, prev_wr);
    for (int p = 0; p < RD_PORTS; p++) begin
      check_rd_resp(p, rd_resp[p], prev_rd[p], prev_mask[4*p +: 4]);
    end
  endtask

  // turn the parsed line into DUT inputs and the expected responses
  task automatic apply_line(input logic idle);
    dc_wr_req_t w;
    dc_rd_req_t r;
    w            = '0;
    w.valid      = f_wv[0] & ~idle;
    w.tag_update = f_wf[0];
    w.way        = f_wway[WAY_W-1:0];
    w.paddr      = f_wpaddr;
    w.be         = f_wbe;
    w.data       = f_wdata;
    wr_req      <= w;
    for (int p = 0; p < RD_PORTS; p++) begin
      r.valid    = f_rv[p][0] & ~idle;
      r.h_pri    = f_rh[p][0];
      r.paddr    = f_ra[p];
      rd_req[p] <= r;
    end
  endtask

  task automatic latch_expected();
    prev_wr.hit  = f_ewr[1];
    prev_wr.miss = f_ewr[0];
    for (int p = 0; p < RD_PORTS; p++) begin
      prev_rd[p]               = '0;
      prev_rd[p].hit           = f_fl[p][2];
      prev_rd[p].miss          = f_fl[p][1];
      prev_rd[p].conflict      = f_fl[p][0];
      prev_rd[p].hit_way       = f_way[p][WAY_W-1:0];
      prev_rd[p].data          = f_edata[p];
      prev_rd[p].replace_valid = f_rvld[p][0];
      prev_rd[p].replace_way   = f_rway[p][WAY_W-1:0];
      prev_rd[p].replace_data  = f_edata[p];
      prev_rd[p].replace_paddr = f_erpa[p];
    end
    prev_mask = f_mask;
    have_prev = 1'b1;
  endtask

  initial begin
    int fd;
    int n;
    int cycles;
    int wait_cycles;
    reg [8*400-1:0] line_buf;
    have_prev   = 1'b0;
    cycles      = 0;
    wait_cycles = 0;
    while (reset_n !== 1'b1) begin
      @(posedge clk);
      wait_cycles++;
      if (wait_cycles > RESET_WAIT) begin
        abort_run("reset was never released");
      end
    end
    fd = $fopen("test/dcache_array_stim.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the stimulus file test/dcache_array_stim.txt");
    end
    while (!$feof(fd)) begin
      line_buf = '0;
      n = $fgets(line_buf, fd);
      n = $sscanf(line_buf,
                  "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                  f_wv, f_wf, f_wway, f_wpaddr, f_wbe, f_wdata,
                  f_rv[0], f_rh[0], f_ra[0], f_rv[1], f_rh[1], f_ra[1],
                  f_rv[2], f_rh[2], f_ra[2], f_ewr,
                  f_fl[0], f_way[0], f_rvld[0], f_rway[0], f_edata[0], f_erpa[0],
                  f_fl[1], f_way[1], f_rvld[1], f_rway[1], f_edata[1], f_erpa[1],
                  f_fl[2], f_way[2], f_rvld[2], f_rway[2], f_edata[2], f_erpa[2],
                  f_mask);
      if (n == NUM_FIELDS) begin
        @(posedge clk);
        apply_line(1'b0);
        @(negedge clk);
        if (have_prev) begin
          verify_responses();
        end
        latch_expected();
        cycles++;
        if (cycles > MAX_CYCLES) begin
          abort_run("stimulus file ran past the cycle limit");
        end
      end else if (n > 0) begin
        abort_run($sformatf("stimulus line %0d is malformed", cycles + 1));
      end
    end
    $fclose(fd);
    // flush the last response
    @(posedge clk);
    apply_line(1'b1);
    @(negedge clk);
    if (have_prev) begin
      verify_responses();
    end
    if (cycles > 0) begin
      $display(">>> PASS");
    end else begin
      abort_run("no stimulus lines were applied");
    end
    $finish;
  end

endmodule

// File: test/dcache_array_stim.txt
# wv wf wway wpaddr wbe wdata | r0..r2: valid h_pri paddr | exp wr {hit,miss}
# per port: {hit,miss,conflict} hit_way replace_valid replace_way data replace_paddr | mask
0 0 0 0 0 0 1 0 00000110 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 002
0 0 0 0 0 0 1 0 00000210 0 0 0 0 0 0 0 2 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 002
0 0 0 0 0 0 1 0 00000110 0 0 0 0 0 0 0 2 0 0 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 002
0 0 0 0 0 0 1 0 00000110 0 0 0 0 0 0 0 2 0 0 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 002
0 0 0 0 0 0 1 0 00000110 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 002
1 1 0 00001020 ffff 0f0e0d0c0b0a09080706050403020100 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 000
1 1 1 00002020 ffff 1f1e1d1c1b1a19181716151413121110 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 000
1 1 2 00003020 ffff 2f2e2d2c2b2a29282726252423222120 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 000
1 1 3 00004020 ffff 3f3e3d3c3b3a39383736353433323130 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 000
1 1 1 00005050 ffff 4f4e4d4c4b4a49484746454443424140 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 000
0 0 0 0 0 0 1 0 00001020 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 000
0 0 0 0 0 0 1 0 00001028 0 0 0 0 0 0 0 4 0 0 0 0f0e0d0c0b0a09080706050403020100 0 0 0 0 0 0 0 0 0 0 0 0 0 001
0 0 0 0 0 0 1 0 00003020 0 0 0 0 0 0 0 4 2 0 0 2f2e2d2c2b2a29282726252423222120 0 0 0 0 0 0 0 0 0 0 0 0 0 001
0 0 0 0 0 0 1 0 00004020 0 0 0 0 0 0 0 4 3 0 0 3f3e3d3c3b3a39383736353433323130 0 0 0 0 0 0 0 0 0 0 0 0 0 001
0 0 0 0 0 0 0 0 0 1 0 00005054 0 0 0 0 0 0 0 0 0 0 4 1 0 0 4f4e4d4c4b4a49484746454443424140 0 0 0 0 0 0 0 010
0 0 0 0 0 0 0 0 0 0 0 0 1 0 00002020 0 0 0 0 0 0 0 0 0 0 0 0 0 4 1 0 0 1f1e1d1c1b1a19181716151413121110 0 100
1 0 0 00001020 000f aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa 1 0 00002020 0 0 0 0 0 0 2 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 000
1 0 0 00009020 ffff 55555555555555555555555555555555 0 0 0 1 0 00001020 0 0 0 1 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 000
0 0 0 0 0 0 1 0 00009020 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 000
0 0 0 0 0 0 1 0 00001020 0 0 0 0 0 0 0 4 0 0 0 0f0e0d0c0b0a090807060504aaaaaaaa 0 0 0 0 0 0 0 0 0 0 0 0 0 001
0 0 0 0 0 0 1 0 00009020 0 0 0 0 0 0 0 2 0 1 0 0f0e0d0c0b0a090807060504aaaaaaaa 00001020 0 0 0 0 0 0 0 0 0 0 0 0 006
0 0 0 0 0 0 1 0 00002020 1 0 00002028 1 0 00003020 0 4 1 0 0 1f1e1d1c1b1a19181716151413121110 0 4 1 0 0 1f1e1d1c1b1a19181716151413121110 0 1 0 0 0 0 0 011
0 0 0 0 0 0 1 0 00004020 1 0 00003024 1 1 0000302c 0 1 0 0 0 0 0 4 2 0 0 2f2e2d2c2b2a29282726252423222120 0 4 2 0 0 2f2e2d2c2b2a29282726252423222120 0 110
0 0 0 0 0 0 1 0 00004020 1 1 00004028 1 1 00003020 0 4 3 0 0 3f3e3d3c3b3a39383736353433323130 0 4 3 0 0 3f3e3d3c3b3a39383736353433323130 0 1 0 0 0 0 0 011
0 0 0 0 0 0 1 0 00005050 0 1 00003020 1 0 00009020 0 4 1 0 0 4f4e4d4c4b4a49484746454443424140 0 0 0 0 0 0 0 1 0 0 0 0 0 001
1 1 0 00007070 ffff 5f5e5d5c5b5a59585756555453525150 1 0 00002020 1 0 00003020 1 0 00004020 1 1 0 0 0 0 0 1 0 0 0 0 0 1 0 0 0 0 0 000
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 000
0 0 0 0 0 0 1 0 0000a020 0 0 0 0 0 0 0 2 0 1 1 1f1e1d1c1b1a19181716151413121110 00002020 0 0 0 0 0 0 0 0 0 0 0 0 006
0 0 0 0 0 0 0 0 0 1 0 0000b024 0 0 0 0 0 0 0 0 0 0 2 0 1 2 2f2e2d2c2b2a29282726252423222120 00003020 0 0 0 0 0 0 060
0 0 0 0 0 0 0 0 0 0 0 0 1 0 0000c028 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 1 3 3f3e3d3c3b3a39383736353433323130 00004020 600
0 0 0 0 0 0 1 0 0000d020 0 0 0 0 0 0 0 2 0 1 0 0f0e0d0c0b0a090807060504aaaaaaaa 00001020 0 0 0 0 0 0 0 0 0 0 0 0 006
0 0 0 0 0 0 1 0 0000e050 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 002
0 0 0 0 0 0 1 0 0000f050 0 0 0 0 0 0 0 2 0 1 1 4f4e4d4c4b4a49484746454443424140 00005050 0 0 0 0 0 0 0 0 0 0 0 0 006
0 0 0 0 0 0 1 0 00011020 1 0 00011024 0 0 0 0 2 0 1 1 1f1e1d1c1b1a19181716151413121110 00002020 2 0 1 1 1f1e1d1c1b1a19181716151413121110 00002020 0 0 0 0 0 0 066
0 0 0 0 0 0 1 0 00012020 0 0 0 0 0 0 0 2 0 1 2 2f2e2d2c2b2a29282726252423222120 00003020 0 0 0 0 0 0 0 0 0 0 0 0 006
0 0 0 0 0 0 1 0 00007074 0 0 0 0 0 0 0 4 0 0 0 5f5e5d5c5b5a59585756555453525150 0 0 0 0 0 0 0 0 0 0 0 0 0 001

// File: tb.f
source/dcache_pkg.sv
source/dcache_read_arb.sv
source/dcache_tag_array.sv
source/dcache_data_array.sv
source/dcache_hit_resp.sv
source/dcache_array.sv
test/tb_dcache_array.sv
